// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := detail_filter_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
rtl/detail_pkg.sv
rtl/neighborhood_sum.sv
rtl/raster_tracker.sv
rtl/contrast_detector.sv
rtl/detail_filter_top.sv
testbench/tb_clock_gen.sv
testbench/detail_filter_assert.sv
testbench/detail_filter_tb.sv

// File: rtl/contrast_detector.sv
`timescale 1ns/1ps

module contrast_detector #(
    parameter int THRESH = 2000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  detail_pkg::win_sum_t  i_win_sum,
    input  detail_pkg::pos_info_t i_pos,
    output detail_pkg::detail_t   o_result
);
    import detail_pkg::*;

    logic [WIN_SUM_W-1:0]       hist [REGION_N];  // hist[0] is the newest window sum
    logic [REGION_W-1:0]        region_sum;
    logic [REGION_W-1:0]        region_next;
    pos_info_t                  acc_pos;
    logic [REGION_W-1:0]        center_x81;
    logic signed [DETAIL_W-1:0] detail;
    logic [DETAIL_W-1:0]        detail_mag;
    detail_t                    result_next;

    // a new row starts from an empty history, so only the new sum counts
    assign region_next = i_pos.row_start ? REGION_W'(i_win_sum.sum) :
                         region_sum + REGION_W'(i_win_sum.sum) - REGION_W'(hist[REGION_N-1]);

    // **************************************************************************
    // stage 1, sliding region accumulator
    // **************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REGION_N; i++) begin
                hist[i] <= '0;
            end
            region_sum <= '0;
            acc_pos    <= '0;
        end else begin
            acc_pos <= i_pos;
            if (i_win_sum.valid) begin
                hist[0] <= i_win_sum.sum;
                for (int i = 1; i < REGION_N; i++) begin
                    hist[i] <= i_pos.row_start ? '0 : hist[i-1];
                end
                region_sum <= region_next;
            end
        end
    end

    // **************************************************************************
    // stage 2, center against region
    // **************************************************************************
    assign center_x81 = (REGION_W'(acc_pos.center) << 6) +
                        (REGION_W'(acc_pos.center) << 4) +
                        REGION_W'(acc_pos.center);           // 64 + 16 + 1
    assign detail     = $signed({1'b0, center_x81}) - $signed({1'b0, region_sum});
    assign detail_mag = detail[DETAIL_W-1] ? DETAIL_W'(-detail) : DETAIL_W'(detail);

    always_comb begin
        result_next.valid     = acc_pos.valid;
        result_next.detail    = detail;
        result_next.edge_flag = acc_pos.full && (detail_mag > THRESH);
        result_next.full      = acc_pos.full;
        result_next.col       = acc_pos.col;
        result_next.row       = acc_pos.row;
        result_next.frame_end = acc_pos.frame_end;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_result <= '0;
        end else begin
            o_result <= result_next;
        end
    end

endmodule

// File: rtl/detail_filter_top.sv
`timescale 1ns/1ps

module detail_filter_top #(
    parameter int COLS   = 16,
    parameter int ROWS   = 6,
    parameter int THRESH = 2000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  detail_pkg::pix_window_t i_window,
    output detail_pkg::detail_t     o_result
);
    import detail_pkg::*;

    win_sum_t  win_sum;   // 5 cycles after the input
    pos_info_t pos_info;  // same cycle as win_sum

    // **************************************************************************
    // two parallel paths feeding the combiner
    // **************************************************************************
    neighborhood_sum u_neighborhood_sum (
        .clk       (clk),
        .rst       (rst),
        .i_window  (i_window),
        .o_win_sum (win_sum)
    );

    raster_tracker #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) u_raster_tracker (
        .clk      (clk),
        .rst      (rst),
        .i_window (i_window),
        .o_pos    (pos_info)
    );

    contrast_detector #(
        .THRESH (THRESH)
    ) u_contrast_detector (
        .clk       (clk),
        .rst       (rst),
        .i_win_sum (win_sum),
        .i_pos     (pos_info),
        .o_result  (o_result)
    );

endmodule

// File: rtl/detail_pkg.sv
package detail_pkg;

    // **************************************************************************
    // widths
    // **************************************************************************
    parameter int PIX_W     = 8;   // grayscale pixel
    parameter int WIN_SUM_W = 12;  // 3x3 sum, at most 2295
    parameter int REGION_N  = 9;   // window sums per region
    parameter int REGION_W  = 15;  // region sum and 81 x center, at most 20655
    parameter int DETAIL_W  = 16;  // signed center-minus-region difference
    parameter int POS_W     = 10;  // column and row counters

    // **************************************************************************
    // block-to-block bundles
    // **************************************************************************
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] p1;
        logic [PIX_W-1:0] p2;
        logic [PIX_W-1:0] p3;
        logic [PIX_W-1:0] p4;
        logic [PIX_W-1:0] p5;  // center pixel
        logic [PIX_W-1:0] p6;
        logic [PIX_W-1:0] p7;
        logic [PIX_W-1:0] p8;
        logic [PIX_W-1:0] p9;
    } pix_window_t;

    typedef struct packed {
        logic                 valid;
        logic [WIN_SUM_W-1:0] sum;
    } win_sum_t;

    typedef struct packed {
        logic             valid;
        logic [POS_W-1:0] col;
        logic [POS_W-1:0] row;
        logic             row_start;  // first window of a row
        logic             full;       // a whole region of windows is behind this one
        logic             frame_end;  // last window of the frame
        logic [PIX_W-1:0] center;
    } pos_info_t;

    typedef struct packed {
        logic                       valid;
        logic signed [DETAIL_W-1:0] detail;
        logic                       edge_flag;
        logic                       full;
        logic [POS_W-1:0]           col;
        logic [POS_W-1:0]           row;
        logic                       frame_end;
    } detail_t;

endpackage

// File: rtl/neighborhood_sum.sv
`timescale 1ns/1ps

module neighborhood_sum (
    input  logic                    clk,
    input  logic                    rst,
    input  detail_pkg::pix_window_t i_window,
    output detail_pkg::win_sum_t    o_win_sum
);
    import detail_pkg::*;

    logic [4:0]           vld;             // one valid bit per pipeline stage
    logic [PIX_W-1:0]     st1_pix [8];     // p1 to p8 after the input register
    logic [PIX_W-1:0]     st1_p9;
    logic [PIX_W-1:0]     p9_dly [3];      // p9 waits here while the tree runs
    logic [PIX_W:0]       pair_sum [4];
    logic [PIX_W+1:0]     quad_sum [2];
    logic [PIX_W+2:0]     octet_sum;
    logic [WIN_SUM_W-1:0] win_sum;

    // valid walks alongside the data and is the only thing reset clears
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[3:0], i_window.valid};
        end
    end

    // **************************************************************************
    // stage 1, input register
    // **************************************************************************
    always_ff @(posedge clk) begin
        st1_pix[0] <= i_window.p1;
        st1_pix[1] <= i_window.p2;
        st1_pix[2] <= i_window.p3;
        st1_pix[3] <= i_window.p4;
        st1_pix[4] <= i_window.p5;
        st1_pix[5] <= i_window.p6;
        st1_pix[6] <= i_window.p7;
        st1_pix[7] <= i_window.p8;
        st1_p9     <= i_window.p9;
    end

    // **************************************************************************
    // stages 2 to 4, adder tree over p1 to p8
    // **************************************************************************
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            pair_sum[i] <= st1_pix[2*i] + st1_pix[2*i+1];  // each level grows one bit
        end
        for (int i = 0; i < 2; i++) begin
            quad_sum[i] <= pair_sum[2*i] + pair_sum[2*i+1];
        end
        octet_sum <= quad_sum[0] + quad_sum[1];
    end

    // p9 lines up with the octet sum after three more cycles
    always_ff @(posedge clk) begin
        p9_dly[0] <= st1_p9;
        p9_dly[1] <= p9_dly[0];
        p9_dly[2] <= p9_dly[1];
    end

    // **************************************************************************
    // stage 5, octet plus p9
    // **************************************************************************
    always_ff @(posedge clk) begin
        win_sum <= WIN_SUM_W'(octet_sum) + WIN_SUM_W'(p9_dly[2]);
    end

    assign o_win_sum.valid = vld[4];
    assign o_win_sum.sum   = win_sum;

endmodule

// File: rtl/raster_tracker.sv
`timescale 1ns/1ps

module raster_tracker #(
    parameter int COLS = 16,
    parameter int ROWS = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  detail_pkg::pix_window_t i_window,
    output detail_pkg::pos_info_t   o_pos
);
    import detail_pkg::*;

    localparam int DELAY = 5;  // matches the adder tree depth

    logic [POS_W-1:0] col_cnt;
    logic [POS_W-1:0] row_cnt;
    logic             last_col;
    logic             last_row;
    pos_info_t        cur_pos;
    pos_info_t        pos_dly [DELAY];

    assign last_col = (col_cnt == POS_W'(COLS - 1));
    assign last_row = (row_cnt == POS_W'(ROWS - 1));

    // **************************************************************************
    // raster position, stepped only by valid samples
    // **************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_window.valid) begin
            if (last_col) begin
                col_cnt <= '0;
                row_cnt <= last_row ? '0 : row_cnt + 1'b1;  // frame wraps to row 0
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // the counters hold the position of the sample now at the input
    always_comb begin
        cur_pos.valid     = i_window.valid;
        cur_pos.col       = col_cnt;
        cur_pos.row       = row_cnt;
        cur_pos.row_start = i_window.valid && (col_cnt == '0);
        cur_pos.full      = i_window.valid && (col_cnt >= POS_W'(REGION_N - 1));
        cur_pos.frame_end = i_window.valid && last_col && last_row;
        cur_pos.center    = i_window.p5;
    end

    // **************************************************************************
    // delay line, keeps position beside the window sum
    // **************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DELAY; i++) begin
                pos_dly[i] <= '0;
            end
        end else begin
            pos_dly[0] <= cur_pos;
            for (int i = 1; i < DELAY; i++) begin
                pos_dly[i] <= pos_dly[i-1];
            end
        end
    end

    assign o_pos = pos_dly[DELAY-1];

endmodule

// File: testbench/detail_filter_assert.sv
`timescale 1ns/1ps

module detail_filter_assert #(
    parameter int COLS   = 16,
    parameter int ROWS   = 6,
    parameter int THRESH = 2000
) (
    input logic                    clk,
    input logic                    rst,
    input detail_pkg::pix_window_t i_window,
    input detail_pkg::detail_t     i_result
);
    import detail_pkg::*;

    localparam int LATENCY = 7;

    typedef struct packed {
        logic                       valid;
        logic [POS_W-1:0]           col;
        logic [POS_W-1:0]           row;
        logic                       full;
        logic                       frame_end;
        logic                       edge_flag;
        logic signed [DETAIL_W-1:0] detail;
    } expect_t;

    int      ref_col;
    int      ref_row;
    int      row_sums [COLS];     // 3x3 sum of every column seen so far in this row
    int      win_total;
    expect_t next_exp;
    expect_t exp_pipe [LATENCY];  // expected results walk alongside the DUT
    expect_t exp_out;
    logic    armed = 1'b0;
    int      fail_valid = 0;
    int      fail_pos = 0;
    int      fail_detail = 0;
    int      fail_edge = 0;
    int      edge_hi_cnt;
    int      edge_lo_cnt;

    assign win_total = int'(i_window.p1) + int'(i_window.p2) + int'(i_window.p3) +
                       int'(i_window.p4) + int'(i_window.p5) + int'(i_window.p6) +
                       int'(i_window.p7) + int'(i_window.p8) + int'(i_window.p9);

    // ************************************************************************
    // reference result for the sample now at the input
    // ************************************************************************
    always_comb begin
        int region;
        int diff;
        region = win_total;
        for (int k = 1; k < REGION_N; k++) begin
            if (ref_col >= k) begin
                region = region + row_sums[ref_col - k];  // only columns of this row
            end
        end
        diff = 81 * int'(i_window.p5) - region;
        next_exp.valid     = i_window.valid;
        next_exp.col       = POS_W'(ref_col);
        next_exp.row       = POS_W'(ref_row);
        next_exp.full      = ref_col >= REGION_N - 1;
        next_exp.frame_end = (ref_col == COLS - 1) && (ref_row == ROWS - 1);
        next_exp.edge_flag = next_exp.full && (diff > THRESH || -diff > THRESH);
        next_exp.detail    = DETAIL_W'(diff);
    end

    always_ff @(posedge clk) begin
        armed <= 1'b1;
        if (rst) begin
            ref_col <= 0;
            ref_row <= 0;
            for (int i = 0; i < LATENCY; i++) begin
                exp_pipe[i] <= '0;
            end
        end else begin
            exp_pipe[0] <= next_exp;
            for (int i = 1; i < LATENCY; i++) begin
                exp_pipe[i] <= exp_pipe[i-1];
            end
            if (i_window.valid) begin
                row_sums[ref_col] <= win_total;
                if (ref_col == COLS - 1) begin
                    ref_col <= 0;
                    ref_row <= (ref_row == ROWS - 1) ? 0 : ref_row + 1;
                end else begin
                    ref_col <= ref_col + 1;
                end
            end
        end
    end

    assign exp_out = exp_pipe[LATENCY-1];

    // both outcomes of the threshold should be seen on full windows
    always_ff @(posedge clk) begin
        if (rst) begin
            edge_hi_cnt <= 0;
            edge_lo_cnt <= 0;
        end else if (i_result.valid && i_result.full) begin
            if (i_result.edge_flag) begin
                edge_hi_cnt <= edge_hi_cnt + 1;
            end else begin
                edge_lo_cnt <= edge_lo_cnt + 1;
            end
        end
    end

    // ************************************************************************
    // checks on the output port
    // ************************************************************************
    a_valid_delay: assert property (@(posedge clk)
        armed |-> (i_result.valid == exp_out.valid))
        else begin
            fail_valid = fail_valid + 1;
            $error("[FAIL] %0t valid is %b, expected %b", $time,
                   $sampled(i_result.valid), $sampled(exp_out.valid));
        end

    a_position: assert property (@(posedge clk)
        (armed && i_result.valid) |-> (i_result.col == exp_out.col &&
                                       i_result.row == exp_out.row &&
                                       i_result.full == exp_out.full &&
                                       i_result.frame_end == exp_out.frame_end))
        else begin
            fail_pos = fail_pos + 1;
            $error("[FAIL] %0t position col %0d row %0d, expected col %0d row %0d", $time,
                   $sampled(i_result.col), $sampled(i_result.row),
                   $sampled(exp_out.col), $sampled(exp_out.row));
        end

    a_detail: assert property (@(posedge clk)
        (armed && i_result.valid) |-> (i_result.detail == exp_out.detail))
        else begin
            fail_detail = fail_detail + 1;
            $error("[FAIL] %0t detail is %0d, expected %0d", $time,
                   $sampled(i_result.detail), $sampled(exp_out.detail));
        end

    a_edge: assert property (@(posedge clk)
        (armed && i_result.valid) |-> (i_result.edge_flag == exp_out.edge_flag))
        else begin
            fail_edge = fail_edge + 1;
            $error("[FAIL] %0t edge is %b, expected %b", $time,
                   $sampled(i_result.edge_flag), $sampled(exp_out.edge_flag));
        end

endmodule

bind detail_filter_top detail_filter_assert #(
    .COLS   (COLS),
    .ROWS   (ROWS),
    .THRESH (THRESH)
) u_check (
    .clk      (clk),
    .rst      (rst),
    .i_window (i_window),
    .i_result (o_result)
);

// File: testbench/detail_filter_tb.sv
`timescale 1ns/1ps

module detail_filter_tb;
    import detail_pkg::*;

    localparam int COLS         = 16;
    localparam int ROWS         = 6;
    localparam int THRESH       = 2000;
    localparam int RESET_CYCLES = 8;
    localparam int FRAMES       = 2;
    localparam int WAIT_LIMIT   = 2000;

    logic        clk;
    logic        rst;
    pix_window_t window;
    detail_t     result;
    logic [15:0] lfsr = 16'd3;
    int          timeouts = 0;
    int          misses = 0;

    tb_clock_gen #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    detail_filter_top #(
        .COLS   (COLS),
        .ROWS   (ROWS),
        .THRESH (THRESH)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .i_window (window),
        .o_result (result)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic make_random_window(output pix_window_t w);
        logic [15:0] v;
        w = '0;
        w.valid = 1'b1;
        for (int k = 0; k < 9; k++) begin
            take_bits(PIX_W, v);
            w[k*PIX_W +: PIX_W] = v[PIX_W-1:0];
        end
    endtask

    // flat surround with a bright center on about half the windows
    task automatic make_flat_window(output pix_window_t w);
        logic [15:0] v;
        take_bits(1, v);
        w = '0;
        w.valid = 1'b1;
        for (int k = 0; k < 9; k++) begin
            w[k*PIX_W +: PIX_W] = 8'd20;
        end
        w.p5 = v[0] ? 8'd240 : 8'd20;
    endtask

    task automatic send_sample(input pix_window_t w);
        logic [15:0] gap;
        take_bits(2, gap);
        if (gap == 0) begin
            take_bits(2, gap);
            repeat (gap + 1) begin
                @(negedge clk);
                window.valid = 1'b0;
            end
        end
        @(negedge clk);
        window = w;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            timeouts++;
            $display("timeout while waiting for reset to be released");
        end
    endtask

    task automatic wait_frame_end();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = result.valid && result.frame_end;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no frame end at the output within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // ************************************************************************
    // stimulus
    // ************************************************************************
    initial begin
        pix_window_t w;
        int          fails;
        make_random_window(w);
        window = w;  // windows offered during reset must not move a counter or reach the output
        repeat (RESET_CYCLES - 1) @(negedge clk);
        window.valid = 1'b0;
        wait_reset_release();
        for (int frame = 0; frame < FRAMES; frame++) begin
            for (int row = 0; row < ROWS; row++) begin
                for (int col = 0; col < COLS; col++) begin
                    if (row == 2 || row == 4) begin
                        make_flat_window(w);
                    end else begin
                        make_random_window(w);
                    end
                    send_sample(w);
                end
            end
            @(negedge clk);
            window.valid = 1'b0;
            wait_frame_end();
        end
        repeat (10) @(negedge clk);  // let the pipeline drain

        assert (DUT.u_check.edge_hi_cnt > 0) else begin
            misses++;
            $display("edge was never set on a full window");
        end
        assert (DUT.u_check.edge_lo_cnt > 0) else begin
            misses++;
            $display("edge was never clear on a full window");
        end

        fails = DUT.u_check.fail_valid + DUT.u_check.fail_pos +
                DUT.u_check.fail_detail + DUT.u_check.fail_edge;
        $display("[%0t] assertion failures %0d, timeouts %0d, coverage misses %0d",
                 $time, fails, timeouts, misses);
        if (fails == 0 && timeouts == 0 && misses == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,  // 4 ns clock
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;  // released on a falling edge like every other input
    end

endmodule
